// ==== verilog/loader_pkg.sv ====
package loader_pkg;

    // AXI length field, beats minus one
    typedef logic [7:0] axlen_t;

    // transactions issued per batch
    typedef logic [7:0] depth_t;

    typedef logic [1:0] burst_t;
    typedef logic [2:0] axsize_t;

    localparam burst_t BURST_INCR = 2'b01;

    typedef enum logic [1:0] {
        IDLE,
        AX_HANDSHAKE,
        RESP_WAIT
    } loader_state_t;

endpackage

// ==== verilog/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_LEN   = 16
) (
    input  logic                  clk_i,
    input  logic                  arstn_i,

    input  logic [DATA_WIDTH-1:0] data_i,
    input  logic                  valid_i,
    output logic                  full_o,

    output logic [DATA_WIDTH-1:0] data_o,
    output logic                  valid_o,
    input  logic                  ready_i
);

    localparam int PTR_W = (FIFO_LEN > 1) ? $clog2(FIFO_LEN) : 1;
    localparam int CNT_W = $clog2(FIFO_LEN + 1);

    logic [DATA_WIDTH-1:0] mem [FIFO_LEN];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  push;
    logic                  pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_LEN - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push    = valid_i && !full_o; // a push into a full queue is dropped
    assign pop     = ready_i && valid_o;

    assign full_o  = (count == CNT_W'(FIFO_LEN));
    assign valid_o = (count != '0);
    assign data_o  = mem[rd_ptr]; // head shown without a read cycle

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!arstn_i)
        valid_i |-> !full_o)
        else $error("stream_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arstn_i)
        ready_i |-> valid_o)
        else $error("stream_fifo: pop while empty");

endmodule

// ==== verilog/axi_master_loader.sv ====
`timescale 1ns/1ps

module axi_master_loader #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 16,
    parameter int ID_WIDTH   = 5,
    parameter int FIFO_DEPTH = 32,
    parameter int LOADER_ID  = 0
) (
    input  logic                      clk_i,
    input  logic                      arstn_i,

    input  loader_pkg::depth_t        req_depth_i,
    input  logic [ID_WIDTH-1:0]       id_i,
    input  logic                      write_i,
    input  loader_pkg::axlen_t        axlen_i,
    input  logic                      fifo_push_i,

    input  logic                      start_i,
    output logic                      idle_o,
    output logic                      fifo_full_o,

    output logic [ID_WIDTH-1:0]       awid_o,
    output logic [ADDR_WIDTH-1:0]     awaddr_o,
    output loader_pkg::axlen_t        awlen_o,
    output loader_pkg::axsize_t       awsize_o,
    output loader_pkg::burst_t        awburst_o,
    output logic                      awvalid_o,
    input  logic                      awready_i,

    output logic [DATA_WIDTH-1:0]     wdata_o,
    output logic [DATA_WIDTH/8-1:0]   wstrb_o,
    output logic                      wlast_o,
    output logic                      wvalid_o,
    input  logic                      wready_i,

    input  logic [ID_WIDTH-1:0]       bid_i,
    input  logic                      bvalid_i,
    output logic                      bready_o,

    output logic [ID_WIDTH-1:0]       arid_o,
    output logic [ADDR_WIDTH-1:0]     araddr_o,
    output loader_pkg::axlen_t        arlen_o,
    output loader_pkg::axsize_t       arsize_o,
    output loader_pkg::burst_t        arburst_o,
    output logic                      arvalid_o,
    input  logic                      arready_i,

    input  logic [ID_WIDTH-1:0]       rid_i,
    input  logic [DATA_WIDTH-1:0]     rdata_i,
    input  logic                      rlast_i,
    input  logic                      rvalid_i,
    output logic                      rready_o
);

    localparam int DESC_W = ID_WIDTH + 1 + $bits(loader_pkg::axlen_t);

    localparam logic [ADDR_WIDTH-1:0] BASE_ADDR = ADDR_WIDTH'(LOADER_ID * 4);
    localparam logic [DATA_WIDTH-1:0] W_WORD    = DATA_WIDTH'(16'h30 + LOADER_ID);
    localparam loader_pkg::axsize_t   BEAT_SIZE = loader_pkg::axsize_t'($clog2(DATA_WIDTH / 8));

    loader_pkg::loader_state_t state;
    loader_pkg::loader_state_t state_next;
    loader_pkg::depth_t        req_cnt;
    loader_pkg::depth_t        req_cnt_next;
    loader_pkg::axlen_t        beat_cnt;
    loader_pkg::axlen_t        beat_cnt_next;
    loader_pkg::depth_t        b_outst;
    loader_pkg::depth_t        b_outst_next;
    loader_pkg::depth_t        r_outst;
    loader_pkg::depth_t        r_outst_next;
    logic                      aw_done;
    logic                      aw_done_next;
    logic                      w_done;
    logic                      w_done_next;

    logic [ID_WIDTH-1:0]       id_rd;
    loader_pkg::axlen_t        len_rd;
    logic                      write_rd;
    logic                      desc_valid;
    logic                      desc_pop;

    logic                      aw_fire;
    logic                      w_fire;
    logic                      w_last_fire;
    logic                      b_fire;
    logic                      r_last_fire;

    stream_fifo #(
        .DATA_WIDTH (DESC_W),
        .FIFO_LEN   (FIFO_DEPTH)
    ) u_stream_fifo (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .data_i  ({write_i, axlen_i, id_i}),
        .valid_i (fifo_push_i),
        .full_o  (fifo_full_o),
        .data_o  ({write_rd, len_rd, id_rd}),
        .valid_o (desc_valid),
        .ready_i (desc_pop)
    );

    // payload comes straight from the queue head
    assign awid_o    = id_rd;
    assign awaddr_o  = BASE_ADDR;
    assign awlen_o   = len_rd;
    assign awsize_o  = BEAT_SIZE;
    assign awburst_o = loader_pkg::BURST_INCR;

    assign wdata_o   = W_WORD;
    assign wstrb_o   = '1;
    assign bready_o  = 1'b1;

    assign arid_o    = id_rd;
    assign araddr_o  = BASE_ADDR;
    assign arlen_o   = len_rd;
    assign arsize_o  = BEAT_SIZE;
    assign arburst_o = loader_pkg::BURST_INCR;
    assign rready_o  = 1'b1;

    assign idle_o    = (state == loader_pkg::IDLE);

    always_comb begin
        awvalid_o = 1'b0;
        wvalid_o  = 1'b0;
        wlast_o   = 1'b0;
        arvalid_o = 1'b0;
        if (state == loader_pkg::AX_HANDSHAKE && desc_valid) begin
            if (write_rd) begin
                awvalid_o = !aw_done;
                wvalid_o  = !w_done;
                wlast_o   = !w_done && (beat_cnt == len_rd);
            end else begin
                arvalid_o = 1'b1;
            end
        end
    end

    assign aw_fire     = awvalid_o && awready_i;
    assign w_fire      = wvalid_o && wready_i;
    assign w_last_fire = w_fire && wlast_o;
    assign b_fire      = bvalid_i && bready_o;
    assign r_last_fire = rvalid_i && rready_o && rlast_i;

    // write pops once AW and the last W are both through, in either order
    assign desc_pop = write_rd ? ((aw_done || aw_fire) && (w_done || w_last_fire))
                               : (arvalid_o && arready_i);

    always_comb begin
        state_next    = state;
        req_cnt_next  = req_cnt;
        aw_done_next  = (aw_done || aw_fire) && !desc_pop;
        w_done_next   = (w_done || w_last_fire) && !desc_pop;
        beat_cnt_next = w_last_fire ? '0 : beat_cnt + loader_pkg::axlen_t'(w_fire);
        b_outst_next  = b_outst + loader_pkg::depth_t'(desc_pop && write_rd)
                        - loader_pkg::depth_t'(b_fire);
        r_outst_next  = r_outst + loader_pkg::depth_t'(desc_pop && !write_rd)
                        - loader_pkg::depth_t'(r_last_fire);

        case (state)
            loader_pkg::IDLE: begin
                req_cnt_next = req_depth_i;
                if (start_i && desc_valid) begin
                    state_next = loader_pkg::AX_HANDSHAKE;
                end
            end
            loader_pkg::AX_HANDSHAKE: begin
                if (desc_pop) begin
                    req_cnt_next = req_cnt - 1'b1;
                    if (req_cnt == loader_pkg::depth_t'(1)) begin
                        state_next = loader_pkg::RESP_WAIT;
                    end
                end
            end
            loader_pkg::RESP_WAIT: begin
                req_cnt_next = req_depth_i; // size of the next batch
                if (b_outst_next == '0 && r_outst_next == '0) begin
                    state_next = desc_valid ? loader_pkg::AX_HANDSHAKE : loader_pkg::IDLE;
                end
            end
            default: begin
                state_next = loader_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state    <= loader_pkg::IDLE;
            req_cnt  <= '0;
            beat_cnt <= '0;
            b_outst  <= '0;
            r_outst  <= '0;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
        end else begin
            state    <= state_next;
            req_cnt  <= req_cnt_next;
            beat_cnt <= beat_cnt_next;
            b_outst  <= b_outst_next;
            r_outst  <= r_outst_next;
            aw_done  <= aw_done_next;
            w_done   <= w_done_next;
        end
    end

    a_aw_held: assert property (@(posedge clk_i) disable iff (!arstn_i)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awid_o) && $stable(awlen_o))
        else $error("axi_master_loader: AWVALID dropped before AWREADY");

    a_beat_range: assert property (@(posedge clk_i) disable iff (!arstn_i)
        wvalid_o |-> beat_cnt <= len_rd)
        else $error("axi_master_loader: W beat count beyond AWLEN");

    a_no_stray_resp: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (bvalid_i || rvalid_i) |-> (b_outst != '0 || r_outst != '0))
        else $error("axi_master_loader: response with nothing outstanding");

endmodule

// ==== verilog/loader_top.sv ====
`timescale 1ns/1ps

module loader_top #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 16,
    parameter int ID_WIDTH   = 5,
    parameter int FIFO_DEPTH = 32,
    parameter int LOADER_ID  = 0
) (
    input  logic                      clk_i,
    input  logic                      arstn_i,

    input  loader_pkg::depth_t        req_depth_i,
    input  logic [ID_WIDTH-1:0]       id_i,
    input  logic                      write_i,
    input  loader_pkg::axlen_t        axlen_i,
    input  logic                      fifo_push_i,

    input  logic                      start_i,
    output logic                      idle_o,
    output logic                      fifo_full_o,

    output logic [ID_WIDTH-1:0]       awid_o,
    output logic [ADDR_WIDTH-1:0]     awaddr_o,
    output loader_pkg::axlen_t        awlen_o,
    output loader_pkg::axsize_t       awsize_o,
    output loader_pkg::burst_t        awburst_o,
    output logic                      awvalid_o,
    input  logic                      awready_i,

    output logic [DATA_WIDTH-1:0]     wdata_o,
    output logic [DATA_WIDTH/8-1:0]   wstrb_o,
    output logic                      wlast_o,
    output logic                      wvalid_o,
    input  logic                      wready_i,

    input  logic [ID_WIDTH-1:0]       bid_i,
    input  logic                      bvalid_i,
    output logic                      bready_o,

    output logic [ID_WIDTH-1:0]       arid_o,
    output logic [ADDR_WIDTH-1:0]     araddr_o,
    output loader_pkg::axlen_t        arlen_o,
    output loader_pkg::axsize_t       arsize_o,
    output loader_pkg::burst_t        arburst_o,
    output logic                      arvalid_o,
    input  logic                      arready_i,

    input  logic [ID_WIDTH-1:0]       rid_i,
    input  logic [DATA_WIDTH-1:0]     rdata_i,
    input  logic                      rlast_i,
    input  logic                      rvalid_i,
    output logic                      rready_o
);

    axi_master_loader #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .ID_WIDTH   (ID_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH),
        .LOADER_ID  (LOADER_ID)
    ) u_loader (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .req_depth_i (req_depth_i),
        .id_i        (id_i),
        .write_i     (write_i),
        .axlen_i     (axlen_i),
        .fifo_push_i (fifo_push_i),
        .start_i     (start_i),
        .idle_o      (idle_o),
        .fifo_full_o (fifo_full_o),
        .awid_o      (awid_o),
        .awaddr_o    (awaddr_o),
        .awlen_o     (awlen_o),
        .awsize_o    (awsize_o),
        .awburst_o   (awburst_o),
        .awvalid_o   (awvalid_o),
        .awready_i   (awready_i),
        .wdata_o     (wdata_o),
        .wstrb_o     (wstrb_o),
        .wlast_o     (wlast_o),
        .wvalid_o    (wvalid_o),
        .wready_i    (wready_i),
        .bid_i       (bid_i),
        .bvalid_i    (bvalid_i),
        .bready_o    (bready_o),
        .arid_o      (arid_o),
        .araddr_o    (araddr_o),
        .arlen_o     (arlen_o),
        .arsize_o    (arsize_o),
        .arburst_o   (arburst_o),
        .arvalid_o   (arvalid_o),
        .arready_i   (arready_i),
        .rid_i       (rid_i),
        .rdata_i     (rdata_i),
        .rlast_i     (rlast_i),
        .rvalid_i    (rvalid_i),
        .rready_o    (rready_o)
    );

endmodule

// ==== test/loader_checker.sv ====
`timescale 1ns/1ps

module loader_checker #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 16,
    parameter int ID_WIDTH   = 5,
    parameter int FIFO_DEPTH = 32,
    parameter int LOADER_ID  = 0
) (
    input logic                    clk_i,
    input logic                    arstn_i,
    input loader_pkg::depth_t      req_depth_i,
    input logic [ID_WIDTH-1:0]     id_i,
    input logic                    write_i,
    input loader_pkg::axlen_t      axlen_i,
    input logic                    fifo_push_i,
    input logic                    fifo_full_o,
    input logic                    idle_o,
    input logic [ID_WIDTH-1:0]     awid_o,
    input logic [ADDR_WIDTH-1:0]   awaddr_o,
    input loader_pkg::axlen_t      awlen_o,
    input loader_pkg::axsize_t     awsize_o,
    input loader_pkg::burst_t      awburst_o,
    input logic                    awvalid_o,
    input logic                    awready_i,
    input logic [DATA_WIDTH-1:0]   wdata_o,
    input logic [DATA_WIDTH/8-1:0] wstrb_o,
    input logic                    wlast_o,
    input logic                    wvalid_o,
    input logic                    wready_i,
    input logic                    bvalid_i,
    input logic                    bready_o,
    input logic [ID_WIDTH-1:0]     arid_o,
    input logic [ADDR_WIDTH-1:0]   araddr_o,
    input loader_pkg::axlen_t      arlen_o,
    input loader_pkg::axsize_t     arsize_o,
    input loader_pkg::burst_t      arburst_o,
    input logic                    arvalid_o,
    input logic                    arready_i,
    input logic                    rlast_i,
    input logic                    rvalid_i,
    input logic                    rready_o
);

    int errors      = 0;
    int pending     = 0; // descriptors pushed but not yet issued
    int outstanding = 0;
    int batch_cnt   = 0;
    int w_beats     = 0;
    bit aw_seen     = 0;
    bit w_seen      = 0;

    logic                q_write[$];
    loader_pkg::axlen_t  q_len[$];
    logic [ID_WIDTH-1:0] q_id[$];

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic fail_text(input string text);
        $display("%s", text);
        errors++;
    endtask

    function automatic int size_code(input int bytes);
        int code;
        code = 0;
        while ((1 << code) < bytes) begin
            code++;
        end
        return code;
    endfunction

    task automatic drop_head();
        void'(q_write.pop_front());
        void'(q_len.pop_front());
        void'(q_id.pop_front());
    endtask

    task automatic check_issue(input string ch, input logic wr, input logic [ID_WIDTH-1:0] id,
                               input loader_pkg::axlen_t len, input logic [ADDR_WIDTH-1:0] addr,
                               input loader_pkg::axsize_t size, input loader_pkg::burst_t burst);
        if (q_write.size() == 0) begin
            fail_text({ch, " transfer with no queued descriptor"});
        end else begin
            compare({ch, " direction"}, 32'(q_write[0]), 32'(wr));
            compare({ch, "id"}, 32'(q_id[0]), 32'(id));
            compare({ch, "len"}, 32'(q_len[0]), 32'(len));
        end
        compare({ch, "addr"}, 32'(LOADER_ID * 4), 32'(addr));
        compare({ch, "burst"}, 32'(loader_pkg::BURST_INCR), 32'(burst));
        compare({ch, "size"}, 32'(size_code(DATA_WIDTH / 8)), 32'(size));
        if (batch_cnt >= int'(req_depth_i)) begin // this transfer opens a new batch
            if (outstanding != 0) begin
                fail_text({ch, " issued before the previous batch's responses returned"});
            end
            batch_cnt = 0;
        end
        batch_cnt++;
        outstanding++;
        if (outstanding > int'(req_depth_i)) begin
            fail_text("outstanding transactions exceed the batch depth");
        end
    endtask

    task automatic check_beat();
        if (q_write.size() == 0 || !q_write[0]) begin
            fail_text("W transfer with no queued write");
        end else if (w_seen) begin
            fail_text("W transfer after the last beat of the burst");
        end else begin
            compare("wlast", 32'(w_beats == int'(q_len[0])), 32'(wlast_o));
            compare("wdata", 32'(16'h30 + LOADER_ID), 32'(wdata_o));
            compare("wstrb", 32'({(DATA_WIDTH/8){1'b1}}), 32'(wstrb_o));
            w_beats++;
            if (wlast_o) begin
                w_seen  = 1;
                w_beats = 0;
            end
        end
    endtask

    // sampled mid-cycle, where handshakes for the next edge are settled
    always @(negedge clk_i) begin
        if (!arstn_i) begin
            compare("awvalid_o", 32'h0, 32'(awvalid_o));
            compare("wvalid_o", 32'h0, 32'(wvalid_o));
            compare("arvalid_o", 32'h0, 32'(arvalid_o));
            compare("wlast_o", 32'h0, 32'(wlast_o));
            compare("idle_o", 32'h1, 32'(idle_o));
        end else begin
            compare("bready_o", 32'h1, 32'(bready_o));
            compare("rready_o", 32'h1, 32'(rready_o));
            compare("fifo_full_o", 32'(q_write.size() == FIFO_DEPTH), 32'(fifo_full_o));
            if (bvalid_i && bready_o) outstanding--;
            if (rvalid_i && rready_o && rlast_i) outstanding--;
            if (outstanding < 0) begin
                fail_text("response arrived with nothing outstanding");
                outstanding = 0;
            end
            if (idle_o) batch_cnt = 0;
            if (awvalid_o && awready_i) begin
                check_issue("aw", 1'b1, awid_o, awlen_o, awaddr_o, awsize_o, awburst_o);
                aw_seen = 1;
            end
            if (wvalid_o && wready_i) check_beat();
            if (aw_seen && w_seen) begin
                drop_head();
                aw_seen = 0;
                w_seen  = 0;
            end
            if (arvalid_o && arready_i) begin
                check_issue("ar", 1'b0, arid_o, arlen_o, araddr_o, arsize_o, arburst_o);
                if (q_write.size() != 0) drop_head();
            end
            if (fifo_push_i) begin
                q_write.push_back(write_i);
                q_len.push_back(axlen_i);
                q_id.push_back(id_i);
            end
            pending = q_write.size();
        end
    end

endmodule

// ==== test/tb_loader_top.sv ====
`timescale 1ns/1ps

module tb_loader_top;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 16;
    localparam int ID_WIDTH   = 5;
    localparam int FIFO_DEPTH = 8; // small, so the queue does fill up
    localparam int LOADER_ID  = 0;
    localparam int TIMEOUT    = 5000;

    logic clk_i = 1'b0;
    logic arstn_i;
    loader_pkg::depth_t req_depth_i;
    logic [ID_WIDTH-1:0] id_i;
    logic write_i;
    loader_pkg::axlen_t axlen_i;
    logic fifo_push_i;
    logic start_i;
    logic idle_o;
    logic fifo_full_o;
    logic [ID_WIDTH-1:0] awid_o;
    logic [ADDR_WIDTH-1:0] awaddr_o;
    loader_pkg::axlen_t awlen_o;
    loader_pkg::axsize_t awsize_o;
    loader_pkg::burst_t awburst_o;
    logic awvalid_o;
    logic awready_i;
    logic [DATA_WIDTH-1:0] wdata_o;
    logic [DATA_WIDTH/8-1:0] wstrb_o;
    logic wlast_o;
    logic wvalid_o;
    logic wready_i;
    logic [ID_WIDTH-1:0] bid_i;
    logic bvalid_i;
    logic bready_o;
    logic [ID_WIDTH-1:0] arid_o;
    logic [ADDR_WIDTH-1:0] araddr_o;
    loader_pkg::axlen_t arlen_o;
    loader_pkg::axsize_t arsize_o;
    loader_pkg::burst_t arburst_o;
    logic arvalid_o;
    logic arready_i;
    logic [ID_WIDTH-1:0] rid_i;
    logic [DATA_WIDTH-1:0] rdata_i;
    logic rlast_i;
    logic rvalid_i;
    logic rready_o;

    integer seed = 32'hcb95;
    int tb_errors = 0;
    bit timed_out = 0;
    int pushed = 0; // descriptors pushed in this round
    int batch_depth = 1;

    logic [ID_WIDTH-1:0] aw_ids[$];
    logic [ID_WIDTH-1:0] ar_ids[$];
    loader_pkg::axlen_t ar_lens[$];
    int w_bursts = 0;

    always #10 clk_i = ~clk_i;

    loader_top #(
        .DATA_WIDTH (DATA_WIDTH), .ADDR_WIDTH (ADDR_WIDTH), .ID_WIDTH (ID_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH), .LOADER_ID (LOADER_ID)
    ) dut (.*);

    loader_checker #(
        .DATA_WIDTH (DATA_WIDTH), .ADDR_WIDTH (ADDR_WIDTH), .ID_WIDTH (ID_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH), .LOADER_ID (LOADER_ID)
    ) u_checker (.*);

    // slave side, sampled at negedge and driven on the rising edge
    always begin : slave
        logic aw_f, w_last_f, ar_f, b_f, r_f, b_hold, r_hold;
        logic [ID_WIDTH-1:0] aw_id_s, ar_id_s, r_id;
        loader_pkg::axlen_t ar_len_s, r_len;
        bit r_active;
        int r_beat;
        r_active = 0;
        r_beat = 0;
        r_len = '0;
        r_id = '0;
        forever begin
            @(negedge clk_i);
            aw_f = awvalid_o && awready_i;
            w_last_f = wvalid_o && wready_i && wlast_o;
            ar_f = arvalid_o && arready_i;
            b_f = bvalid_i && bready_o;
            r_f = rvalid_i && rready_o;
            b_hold = bvalid_i && !b_f;
            r_hold = rvalid_i && !r_f;
            aw_id_s = awid_o;
            ar_id_s = arid_o;
            ar_len_s = arlen_o;
            @(posedge clk_i);
            if (aw_f) aw_ids.push_back(aw_id_s);
            if (w_last_f) w_bursts++;
            if (ar_f) begin
                ar_ids.push_back(ar_id_s);
                ar_lens.push_back(ar_len_s);
            end
            awready_i <= (($random(seed) & 3) != 0);
            wready_i <= (($random(seed) & 3) != 0);
            arready_i <= (($random(seed) & 3) != 0);
            if (!b_hold) begin // B only once AW and the whole burst are in
                if (aw_ids.size() > 0 && w_bursts > 0 && (($random(seed) & 1) != 0)) begin
                    bvalid_i <= 1'b1;
                    bid_i <= aw_ids.pop_front();
                    w_bursts--;
                end else begin
                    bvalid_i <= 1'b0;
                end
            end
            if (r_f) begin
                if (r_beat == int'(r_len)) r_active = 0;
                else r_beat++;
            end
            if (!r_hold) begin
                if (!r_active && ar_ids.size() > 0) begin
                    r_id = ar_ids.pop_front();
                    r_len = ar_lens.pop_front();
                    r_beat = 0;
                    r_active = 1;
                end
                if (r_active && (($random(seed) & 1) != 0)) begin
                    rvalid_i <= 1'b1;
                    rid_i <= r_id;
                    rlast_i <= (r_beat == int'(r_len));
                    rdata_i <= DATA_WIDTH'($random(seed));
                end else begin
                    rvalid_i <= 1'b0;
                    rlast_i <= 1'b0;
                end
            end
        end
    end

    task automatic push_phase(input int cycles);
        logic full_s, push_s;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk_i);
            full_s = fifo_full_o;
            push_s = fifo_push_i; // a push still in flight, skip a cycle
            @(posedge clk_i);
            if (!full_s && !push_s && (($random(seed) & 1) != 0)) begin
                id_i <= ID_WIDTH'($random(seed));
                write_i <= 1'($random(seed));
                axlen_i <= loader_pkg::axlen_t'($random(seed) & 7);
                fifo_push_i <= 1'b1;
                pushed++;
            end else begin
                fifo_push_i <= 1'b0;
            end
            start_i <= 1'($random(seed));
        end
    endtask

    // top up the round so its last batch is complete
    task automatic fill_batch();
        int cycles;
        cycles = 0;
        while (pushed % batch_depth != 0 && cycles < TIMEOUT) begin
            push_phase(1);
            cycles++;
        end
        if (pushed % batch_depth != 0) begin
            $display("timeout: could not push a whole number of batches");
            tb_errors++;
            timed_out = 1;
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!(idle_o && u_checker.pending == 0 && u_checker.outstanding == 0
                     && !bvalid_i && !rvalid_i) && cycles < TIMEOUT);
        if (cycles >= TIMEOUT) begin
            $display("timeout: loader did not drain and return to idle");
            tb_errors++;
            timed_out = 1;
        end
    endtask

    initial begin
        arstn_i = 1'b0;
        req_depth_i = loader_pkg::depth_t'(1);
        id_i = '0;
        write_i = 1'b0;
        axlen_i = '0;
        fifo_push_i = 1'b0;
        start_i = 1'b0;
        awready_i = 1'b0;
        wready_i = 1'b0;
        arready_i = 1'b0;
        bid_i = '0;
        bvalid_i = 1'b0;
        rid_i = '0;
        rdata_i = '0;
        rlast_i = 1'b0;
        rvalid_i = 1'b0;
        repeat (2) @(posedge clk_i);
        arstn_i <= 1'b1;
        for (int round = 0; round < 8 && !timed_out; round++) begin
            @(posedge clk_i);
            start_i <= 1'b0;
            @(posedge clk_i);
            batch_depth = ($random(seed) & 3) + 1;
            req_depth_i <= loader_pkg::depth_t'(batch_depth);
            pushed = 0;
            push_phase(60);
            fill_batch();
            @(posedge clk_i);
            fifo_push_i <= 1'b0;
            start_i <= 1'b1;
            wait_drained();
        end
        $display("errors: %0d from checker, %0d from testbench", u_checker.errors, tb_errors);
        if (u_checker.errors == 0 && tb_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/loader_pkg.sv
verilog/stream_fifo.sv
verilog/axi_master_loader.sv
verilog/loader_top.sv
test/loader_checker.sv
test/tb_loader_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_loader_top
FILELIST  = build.f
PASS_MSG  = All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
